// ==== bench/tb_csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module tb_csr_unit;

    localparam int RESET_CYCLES    = 10;
    localparam int ACK_TIMEOUT     = 20;
    // about 60 accesses and four timer waits
    localparam int TEST_CYCLES     = RESET_CYCLES + 60 * ACK_TIMEOUT + 4 * 60;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    logic                    clk;
    logic                    reset;
    logic                    csr_req;
    logic                    csr_we;
    csr_pkg::csr_addr_t      csr_addr;
    csr_pkg::csr_word_t      csr_wdata;
    csr_pkg::csr_word_t      csr_rdata;
    logic                    csr_ack;
    logic                    excp_flush;
    logic                    ertn_flush;
    csr_pkg::csr_word_t      era_in;
    csr_pkg::ecode_t         ecode_in;
    csr_pkg::esubcode_t      esubcode_in;
    logic [7:0]              interrupt;
    logic                    has_int;
    logic [1:0]              plv;
    csr_pkg::csr_word_t      eentry;
    csr_pkg::csr_word_t      era;

    int                      errors;
    int                      checks;
    int                      cycle_count;
    int                      ack_cycle;

    csr_unit u_dut (
        .clk         (clk),
        .reset       (reset),
        .csr_req     (csr_req),
        .csr_we      (csr_we),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .csr_rdata   (csr_rdata),
        .csr_ack     (csr_ack),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .era_in      (era_in),
        .ecode_in    (ecode_in),
        .esubcode_in (esubcode_in),
        .interrupt   (interrupt),
        .has_int     (has_int),
        .plv         (plv),
        .eentry      (eentry),
        .era         (era)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(csr_ack) |-> csr_req)
        else begin
            errors++;
            $display("error handshake: csr_ack rose while csr_req was low");
        end

    ack_drops_after_req: assert property (@(posedge clk) disable iff (reset)
        $fell(csr_req) |=> !csr_ack)
        else begin
            errors++;
            $display("error handshake: csr_ack stayed high after csr_req dropped");
        end

    task automatic check_value(input string name, input csr_pkg::csr_word_t expected,
                               input csr_pkg::csr_word_t actual);
        checks++;
        assert (actual == expected)
            else begin
                errors++;
                $display("error %s: expected %h, actual %h", name, expected, actual);
            end
    endtask

    task automatic check_range(input string name, input int lo, input int hi,
                               input int actual);
        checks++;
        assert (actual >= lo && actual <= hi)
            else begin
                errors++;
                $display("error %s: expected %0d to %0d, actual %0d", name, lo, hi, actual);
            end
    endtask

    // entered and left at 2 ns after a rising edge
    task automatic access(input logic we, input csr_pkg::csr_addr_t addr,
                          input csr_pkg::csr_word_t wdata, output csr_pkg::csr_word_t rdata);
        int waited;
        waited    = 0;
        rdata     = '0;
        csr_req   = 1'b1;
        csr_we    = we;
        csr_addr  = addr;
        csr_wdata = wdata;
        while (!csr_ack && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!csr_ack) begin
            errors++;
            $display("error access: no csr_ack for address %h", addr);
        end else begin
            rdata     = csr_rdata;
            ack_cycle = cycle_count;
            // ack is registered on the requester side before req drops
            @(posedge clk);
            #2;
        end
        csr_req = 1'b0;
        waited  = 0;
        while (csr_ack && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (csr_ack) begin
            errors++;
            $display("error access: csr_ack did not drop for address %h", addr);
        end
    endtask

    task automatic write_reg(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_word_t wdata);
        csr_pkg::csr_word_t old;
        access(1'b1, addr, wdata, old);
    endtask

    task automatic read_reg(input csr_pkg::csr_addr_t addr, output csr_pkg::csr_word_t rdata);
        access(1'b0, addr, '0, rdata);
    endtask

    task automatic wait_has_int(input int max_cycles, output int waited);
        waited = 0;
        while (!has_int && waited < max_cycles) begin
            @(posedge clk);
            #2;
            waited++;
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("error watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        csr_pkg::csr_word_t rd;
        csr_pkg::csr_word_t val;
        csr_pkg::csr_word_t prev;
        csr_pkg::csr_word_t rnd;
        int                 waited;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        ack_cycle   = 0;
        reset       = 1'b1;
        csr_req     = 1'b0;
        csr_we      = 1'b0;
        csr_addr    = '0;
        csr_wdata   = '0;
        excp_flush  = 1'b0;
        ertn_flush  = 1'b0;
        era_in      = '0;
        ecode_in    = '0;
        esubcode_in = '0;
        interrupt   = 8'd0;
        rnd         = $urandom(32'h77e045a1);
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;

        read_reg(`CSR_CRMD, rd);
        check_value("reset crmd", `CRMD_RESET, rd);
        read_reg(`CSR_ECTL, rd);
        check_value("reset ectl", 32'h0, rd);
        read_reg(`CSR_ESTAT, rd);
        check_value("reset estat", 32'h0, rd);
        read_reg(`CSR_TCFG, rd);
        check_value("reset tcfg", 32'h0, rd);
        read_reg(`CSR_EENTRY, rd);
        check_value("reset eentry", 32'h0, rd);
        check_value("reset has_int", 32'h0, {31'd0, has_int});

        for (int i = 0; i < 4; i++) begin
            prev = $urandom;
            write_reg(`CSR_SAVE0 + i, prev);
            read_reg(`CSR_SAVE0 + i, rd);
            check_value("save readback", prev, rd);
            val = $urandom;
            access(1'b1, `CSR_SAVE0 + i, val, rd);
            check_value("save write returns old", prev, rd);
            read_reg(`CSR_SAVE0 + i, rd);
            check_value("save second readback", val, rd);
        end
        val = $urandom;
        write_reg(`CSR_EENTRY, val);
        read_reg(`CSR_EENTRY, rd);
        check_value("eentry alignment", val & 32'hffff_ffc0, rd);
        check_value("eentry output", val & 32'hffff_ffc0, eentry);

        // plv 3, ie 1, da kept set
        write_reg(`CSR_CRMD, 32'hf);
        check_value("plv before trap", 32'd3, {30'd0, plv});
        rnd         = $urandom;
        ecode_in    = rnd[5:0];
        esubcode_in = rnd[14:6];
        era_in      = $urandom;
        excp_flush  = 1'b1;
        @(posedge clk);
        #2;
        excp_flush = 1'b0;
        check_value("plv after trap", 32'd0, {30'd0, plv});
        check_value("era after trap", era_in, era);
        read_reg(`CSR_PRMD, rd);
        check_value("prmd after trap", 32'h7, rd);
        read_reg(`CSR_ESTAT, rd);
        check_value("estat codes", {1'b0, esubcode_in, ecode_in, 16'd0}, rd);
        ertn_flush = 1'b1;
        @(posedge clk);
        #2;
        ertn_flush = 1'b0;
        check_value("plv after return", 32'd3, {30'd0, plv});

        write_reg(`CSR_ECTL, 32'h1 << `HWI_LO);
        interrupt = 8'h01;
        wait_has_int(2, waited);
        check_value("hardware interrupt", 32'h1, {31'd0, has_int});
        write_reg(`CSR_CRMD, 32'hb);
        check_value("interrupt masked by ie", 32'h0, {31'd0, has_int});
        interrupt = 8'h00;
        write_reg(`CSR_ECTL, 32'h1 << `TI_BIT);
        write_reg(`CSR_CRMD, 32'hf);

        // one-shot with initval 5
        write_reg(`CSR_TCFG, (32'd5 << 2) | 32'h1);
        wait_has_int(40, waited);
        check_value("one-shot timer irq", 32'h1, {31'd0, has_int});
        check_range("one-shot delay", 20, 23, cycle_count - ack_cycle);
        write_reg(`CSR_TICLR, 32'h1 << `TICLR_CLR);
        check_value("ticlr clears irq", 32'h0, {31'd0, has_int});
        // stopped timer parks at all ones
        read_reg(`CSR_TVAL, rd);
        check_value("one-shot tval parked", 32'hffff_ffff, rd);

        write_reg(`CSR_TCFG, (32'd5 << 2) | 32'h3);
        wait_has_int(40, waited);
        check_value("periodic first irq", 32'h1, {31'd0, has_int});
        write_reg(`CSR_TICLR, 32'h1 << `TICLR_CLR);
        check_value("periodic irq cleared", 32'h0, {31'd0, has_int});
        wait_has_int(40, waited);
        check_value("periodic irq again", 32'h1, {31'd0, has_int});
        write_reg(`CSR_TCFG, 32'h0);
        write_reg(`CSR_TICLR, 32'h1 << `TICLR_CLR);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_bus_if.sv
hdl/csr_access_stage.sv
hdl/csr_trap_regs.sv
hdl/csr_timer.sv
hdl/csr_unit.sv
bench/tb_csr_unit.sv

// ==== hdl/csr_access_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_access_stage (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     csr_req,
    input  wire                     csr_we,
    input  wire csr_pkg::csr_addr_t csr_addr,
    input  wire csr_pkg::csr_word_t csr_wdata,
    output logic                    csr_ack,
    output csr_pkg::csr_word_t      csr_rdata,
    csr_bus_if.stage                bus
);

    logic               pending;
    logic               start;
    logic               req_we;
    csr_pkg::csr_addr_t req_addr;
    csr_pkg::csr_data_u req_wdata;

    // accept only from idle, with the previous ack already dropped
    assign start = csr_req && !csr_ack && !pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            csr_ack <= 1'b0;
        end else begin
            pending <= start;
            if (pending) begin
                csr_ack <= 1'b1;
            end else if (!csr_req) begin
                csr_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_we        <= csr_we;
            req_addr      <= csr_addr;
            req_wdata.raw <= csr_wdata;
        end
        // banks still show the value from before this write
        if (pending) begin
            csr_rdata <= bus.trap_rdata | bus.timer_rdata;
        end
    end

    assign bus.bus_valid = pending;
    assign bus.bus_we    = req_we;
    assign bus.bus_addr  = req_addr;
    assign bus.bus_wdata = req_wdata;

    ack_needs_req: assert property (
        @(posedge clk) disable iff (reset)
        $rose(csr_ack) |-> csr_req
    );

    strobe_one_cycle: assert property (
        @(posedge clk) disable iff (reset)
        bus.bus_valid |=> !bus.bus_valid
    );

endmodule

`default_nettype wire

// ==== hdl/csr_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface csr_bus_if;

    logic               bus_valid;
    logic               bus_we;
    csr_pkg::csr_addr_t bus_addr;
    csr_pkg::csr_data_u bus_wdata;
    csr_pkg::csr_word_t trap_rdata;
    csr_pkg::csr_word_t timer_rdata;

    modport stage (output bus_valid, bus_we, bus_addr, bus_wdata,
                   input  trap_rdata, timer_rdata);

    modport trap  (input  bus_valid, bus_we, bus_addr, bus_wdata,
                   output trap_rdata);

    modport timer (input  bus_valid, bus_we, bus_addr, bus_wdata,
                   output timer_rdata);

endinterface

`default_nettype wire

// ==== hdl/csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// csr numbers
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ECTL        14'h004
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033
`define CSR_TCFG        14'h041
`define CSR_TVAL        14'h042
`define CSR_TICLR       14'h044

// interrupt fields shared by ECTL.LIE and ESTAT.IS
`define INT_NUM         13
`define HWI_LO          2
`define HWI_HI          9
`define TI_BIT          11

// estat code fields, low bit of each
`define ECODE_LO        16
`define ESUBCODE_LO     22

`define TICLR_CLR       0
`define EENTRY_ALIGN    6

// reset values
`define CRMD_RESET      32'h0000_0008
`define CSR_RESET_ZERO  32'h0000_0000

`endif

// ==== hdl/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // CRMD layout, PLV in the low bits
    typedef struct packed {
        logic [22:0] rsvd;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_fields_t;

    // TCFG layout, initval is in units of four cycles
    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_fields_t;

    // one write word, seen raw or through a register layout
    typedef union packed {
        csr_word_t    raw;
        crmd_fields_t crmd;
        tcfg_fields_t tcfg;
    } csr_data_u;

endpackage

`default_nettype wire

// ==== hdl/csr_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_timer (
    input  wire      clk,
    input  wire      reset,
    csr_bus_if.timer bus,
    output logic     timer_irq
);

    csr_pkg::tcfg_fields_t tcfg;
    csr_pkg::csr_word_t    tval;
    logic                  timer_en;
    logic                  tcfg_seen;
    logic                  tcfg_wen;
    logic                  ticlr_wen;
    logic                  expire;

    assign tcfg_wen  = bus.bus_valid && bus.bus_we && (bus.bus_addr == `CSR_TCFG);
    assign ticlr_wen = bus.bus_valid && bus.bus_we && (bus.bus_addr == `CSR_TICLR)
                       && bus.bus_wdata.raw[`TICLR_CLR];
    assign expire    = timer_en && (tval == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg <= `CSR_RESET_ZERO;
        end else if (tcfg_wen) begin
            tcfg <= bus.bus_wdata.tcfg;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_en  <= 1'b0;
            tcfg_seen <= 1'b0;
            tval      <= `CSR_RESET_ZERO;
        end else if (tcfg_wen) begin
            timer_en  <= bus.bus_wdata.tcfg.en;
            tcfg_seen <= 1'b1;
            tval      <= {bus.bus_wdata.tcfg.initval, 2'b00};
        end else if (expire) begin
            // one-shot parks at all ones
            timer_en <= tcfg.periodic;
            tval     <= tcfg.periodic ? {tcfg.initval, 2'b00} : '1;
        end else if (timer_en) begin
            tval <= tval - 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_irq <= 1'b0;
        end else if (ticlr_wen) begin
            timer_irq <= 1'b0;
        end else if (expire) begin
            timer_irq <= 1'b1;
        end
    end

    always_comb begin
        case (bus.bus_addr)
            `CSR_TCFG: bus.timer_rdata = tcfg;
            `CSR_TVAL: bus.timer_rdata = tval;
            default:   bus.timer_rdata = '0;
        endcase
    end

    enable_after_config: assert property (
        @(posedge clk) disable iff (reset)
        timer_en |-> tcfg_seen
    );

endmodule

`default_nettype wire

// ==== hdl/csr_trap_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_trap_regs (
    input  wire                     clk,
    input  wire                     reset,
    csr_bus_if.trap                 bus,
    input  wire                     timer_irq,
    input  wire [7:0]               interrupt,
    input  wire                     excp_flush,
    input  wire                     ertn_flush,
    input  wire csr_pkg::csr_word_t era_in,
    input  wire csr_pkg::ecode_t    ecode_in,
    input  wire csr_pkg::esubcode_t esubcode_in,
    output logic                    has_int,
    output logic [1:0]              plv,
    output csr_pkg::csr_word_t      eentry,
    output csr_pkg::csr_word_t      era
);

    csr_pkg::crmd_fields_t    crmd;
    logic [1:0]               prmd_pplv;
    logic                     prmd_pie;
    logic [`INT_NUM-1:0]      lie;
    logic [1:0]               swi;
    logic [7:0]               hwi;
    csr_pkg::ecode_t          ecode;
    csr_pkg::esubcode_t       esubcode;
    logic [31:`EENTRY_ALIGN]  eentry_hi;
    csr_pkg::csr_word_t       save_r [4];
    logic [`INT_NUM-1:0]      estat_is;
    csr_pkg::csr_word_t       estat_word;
    logic                     wen;
    logic                     crmd_wen;
    logic                     prmd_wen;
    logic                     ectl_wen;
    logic                     estat_wen;
    logic                     era_wen;
    logic                     eentry_wen;
    logic                     save_wen;

    assign wen        = bus.bus_valid && bus.bus_we;
    assign crmd_wen   = wen && (bus.bus_addr == `CSR_CRMD);
    assign prmd_wen   = wen && (bus.bus_addr == `CSR_PRMD);
    assign ectl_wen   = wen && (bus.bus_addr == `CSR_ECTL);
    assign estat_wen  = wen && (bus.bus_addr == `CSR_ESTAT);
    assign era_wen    = wen && (bus.bus_addr == `CSR_ERA);
    assign eentry_wen = wen && (bus.bus_addr == `CSR_EENTRY);
    // SAVE0..3 sit on four consecutive numbers
    assign save_wen   = wen && ((bus.bus_addr & ~14'h3) == `CSR_SAVE0);

    // trap events take the register before any CSR write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= `CRMD_RESET;
        end else if (excp_flush) begin
            crmd.plv <= 2'd0;
            crmd.ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd.plv <= prmd_pplv;
            crmd.ie  <= prmd_pie;
        end else if (crmd_wen) begin
            crmd.plv  <= bus.bus_wdata.crmd.plv;
            crmd.ie   <= bus.bus_wdata.crmd.ie;
            crmd.da   <= bus.bus_wdata.crmd.da;
            crmd.pg   <= bus.bus_wdata.crmd.pg;
            crmd.datf <= bus.bus_wdata.crmd.datf;
            crmd.datm <= bus.bus_wdata.crmd.datm;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= 2'd0;
            prmd_pie  <= 1'b0;
        end else if (excp_flush) begin
            prmd_pplv <= crmd.plv;
            prmd_pie  <= crmd.ie;
        end else if (prmd_wen) begin
            prmd_pplv <= bus.bus_wdata.raw[1:0];
            prmd_pie  <= bus.bus_wdata.raw[2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lie       <= '0;
            swi       <= 2'd0;
            hwi       <= 8'd0;
            ecode     <= '0;
            esubcode  <= '0;
            eentry_hi <= '0;
        end else begin
            hwi <= interrupt;
            if (ectl_wen) begin
                lie <= bus.bus_wdata.raw[`INT_NUM-1:0];
            end
            if (estat_wen) begin
                swi <= bus.bus_wdata.raw[1:0];
            end
            if (excp_flush) begin
                ecode    <= ecode_in;
                esubcode <= esubcode_in;
            end
            if (eentry_wen) begin
                eentry_hi <= bus.bus_wdata.raw[31:`EENTRY_ALIGN];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excp_flush) begin
            era <= era_in;
        end else if (era_wen) begin
            era <= bus.bus_wdata.raw;
        end
        if (save_wen) begin
            save_r[bus.bus_addr[1:0]] <= bus.bus_wdata.raw;
        end
    end

    always_comb begin
        estat_is                   = '0;
        estat_is[1:0]              = swi;
        estat_is[`HWI_HI:`HWI_LO]  = hwi;
        estat_is[`TI_BIT]          = timer_irq;
        estat_word                 = '0;
        estat_word[`INT_NUM-1:0]   = estat_is;
        estat_word[`ECODE_LO +: 6] = ecode;
        estat_word[`ESUBCODE_LO +: 9] = esubcode;
    end

    always_comb begin
        case (bus.bus_addr)
            `CSR_CRMD:   bus.trap_rdata = crmd;
            `CSR_PRMD:   bus.trap_rdata = {29'd0, prmd_pie, prmd_pplv};
            `CSR_ECTL:   bus.trap_rdata = {{(32-`INT_NUM){1'b0}}, lie};
            `CSR_ESTAT:  bus.trap_rdata = estat_word;
            `CSR_ERA:    bus.trap_rdata = era;
            `CSR_EENTRY: bus.trap_rdata = eentry;
            `CSR_SAVE0,
            `CSR_SAVE1,
            `CSR_SAVE2,
            `CSR_SAVE3:  bus.trap_rdata = save_r[bus.bus_addr[1:0]];
            default:     bus.trap_rdata = '0;
        endcase
    end

    assign has_int = (|(lie & estat_is)) && crmd.ie;
    assign plv     = crmd.plv;
    assign eentry  = {eentry_hi, {`EENTRY_ALIGN{1'b0}}};

    flush_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(excp_flush && ertn_flush)
    );

endmodule

`default_nettype wire

// ==== hdl/csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       csr_req,
    input  wire                       csr_we,
    input  wire csr_pkg::csr_addr_t   csr_addr,
    input  wire csr_pkg::csr_word_t   csr_wdata,
    output csr_pkg::csr_word_t        csr_rdata,
    output logic                      csr_ack,
    input  wire                       excp_flush,
    input  wire                       ertn_flush,
    input  wire csr_pkg::csr_word_t   era_in,
    input  wire csr_pkg::ecode_t      ecode_in,
    input  wire csr_pkg::esubcode_t   esubcode_in,
    input  wire [7:0]                 interrupt,
    output logic                      has_int,
    output logic [1:0]                plv,
    output csr_pkg::csr_word_t        eentry,
    output csr_pkg::csr_word_t        era
);

    logic timer_irq;

    csr_bus_if u_bus ();

    csr_access_stage u_stage (
        .clk       (clk),
        .reset     (reset),
        .csr_req   (csr_req),
        .csr_we    (csr_we),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_ack   (csr_ack),
        .csr_rdata (csr_rdata),
        .bus       (u_bus.stage)
    );

    csr_trap_regs u_trap (
        .clk         (clk),
        .reset       (reset),
        .bus         (u_bus.trap),
        .timer_irq   (timer_irq),
        .interrupt   (interrupt),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .era_in      (era_in),
        .ecode_in    (ecode_in),
        .esubcode_in (esubcode_in),
        .has_int     (has_int),
        .plv         (plv),
        .eentry      (eentry),
        .era         (era)
    );

    csr_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .bus       (u_bus.timer),
        .timer_irq (timer_irq)
    );

endmodule

`default_nettype wire
